// ==== verilog/spi_xip_pkg.sv ====
`default_nettype none

package spi_xip_pkg;

  // XIP window, reads only
  localparam logic [31:0] flash_base = 32'h3000_0000;
  localparam logic [31:0] flash_last = 32'h3FFF_FFFF;

  // SPI master register window
  localparam logic [31:0] ctrl_base = 32'h1000_1000;
  localparam logic [31:0] ctrl_last = 32'h1000_1FFF;

  // Register offsets on the register bus
  // RX0 and TX0 share offset 0, split by direction
  localparam logic [4:0] reg_rx0     = 5'h00;
  localparam logic [4:0] reg_tx0     = 5'h00;
  localparam logic [4:0] reg_tx1     = 5'h04;
  localparam logic [4:0] reg_ctrl    = 5'h10;
  localparam logic [4:0] reg_divider = 5'h14;
  localparam logic [4:0] reg_ss      = 5'h18;

  // CTRL layout
  localparam int ctrl_go_bit    = 8;
  localparam int ctrl_len_lsb   = 0;
  // Length 0 selects a full 64 bit frame
  localparam int ctrl_len_width = 7;

  localparam logic [7:0]  flash_read_op = 8'h03;
  localparam int          ss_width      = 8;
  // SCK half period of two clocks
  localparam logic [15:0] xip_divider   = 16'd1;

  // XIP sequencer steps, in issue order
  localparam logic [3:0] seq_idle   = 4'd0;
  localparam logic [3:0] seq_tx1    = 4'd1;
  localparam logic [3:0] seq_tx0    = 4'd2;
  localparam logic [3:0] seq_div    = 4'd3;
  localparam logic [3:0] seq_ss_on  = 4'd4;
  localparam logic [3:0] seq_go     = 4'd5;
  localparam logic [3:0] seq_poll   = 4'd6;
  localparam logic [3:0] seq_rx0    = 4'd7;
  localparam logic [3:0] seq_ss_off = 4'd8;

  // APB port states
  localparam logic [1:0] port_idle    = 2'd0;
  localparam logic [1:0] port_busy    = 2'd1;
  localparam logic [1:0] port_respond = 2'd2;

  // 64 bit transmit frame, register view or flash command view
  typedef union packed {
    struct packed {
      logic [31:0] tx1;
      logic [31:0] tx0;
    } raw;
    struct packed {
      logic [7:0]  opcode;
      logic [23:0] address;
      logic [31:0] dummy;
    } cmd;
  } tx_frame_u;

endpackage

`default_nettype wire

// ==== verilog/apb_spi_port.sv ====
`default_nettype none
`timescale 1ns/100ps

module apb_spi_port (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] paddr_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [31:0] pwdata_i,
  input  logic [3:0]  pstrb_i,
  output logic        pready_o,
  output logic [31:0] prdata_o,
  output logic        pslverr_o,
  output logic        rq_req_o,
  output logic        rq_we_o,
  output logic [4:0]  rq_addr_o,
  output logic [31:0] rq_wdata_o,
  output logic [3:0]  rq_sel_o,
  input  logic        rq_ack_i,
  input  logic [31:0] rq_rdata_i,
  output logic        xip_start_o,
  output logic [23:0] xip_addr_o,
  input  logic        xip_done_i,
  input  logic [31:0] xip_data_i
);
  import spi_xip_pkg::*;

  logic [1:0] state_q;
  logic       access;
  logic       in_ctrl;
  logic       in_flash;
  logic       bad_addr;
  logic       finish;

  // Window decode
  assign access   = psel_i & penable_i;
  assign in_ctrl  = (paddr_i >= ctrl_base) && (paddr_i <= ctrl_last);
  assign in_flash = (paddr_i >= flash_base) && (paddr_i <= flash_last);
  assign bad_addr = (state_q == port_idle) & access & ~in_ctrl & ~in_flash;

  // Register ack or sequencer done ends a busy access
  assign finish = (state_q == port_busy) &
                  ((rq_req_o & rq_ack_i) | (xip_start_o & xip_done_i));

  // Errors complete in the first access cycle
  assign pready_o  = bad_addr | finish;
  assign pslverr_o = bad_addr;
  assign prdata_o  = xip_start_o ? xip_data_i : rq_rdata_i;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q     <= port_idle;
      rq_req_o    <= 1'b0;
      xip_start_o <= 1'b0;
    end else begin
      case (state_q)
        port_idle: begin
          if (access && in_ctrl) begin
            rq_req_o <= 1'b1;
            state_q  <= port_busy;
          end else if (access && in_flash) begin
            xip_start_o <= 1'b1;
            state_q     <= port_busy;
          end else if (bad_addr) begin
            state_q <= port_respond;
          end
        end
        port_busy: begin
          if (finish) begin
            rq_req_o    <= 1'b0;
            xip_start_o <= 1'b0;
            state_q     <= port_respond;
          end
        end
        // Hold off until the APB access phase ends
        default: begin
          if (!penable_i) begin
            state_q <= port_idle;
          end
        end
      endcase
    end
  end

  // Request fields captured at access start
  always_ff @(posedge clock) begin
    if (state_q == port_idle && access) begin
      rq_we_o    <= pwrite_i;
      rq_addr_o  <= paddr_i[4:0];
      rq_wdata_o <= pwdata_i;
      rq_sel_o   <= pwrite_i ? pstrb_i : 4'h0;
      xip_addr_o <= paddr_i[23:0];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/xip_read_seq.sv ====
`default_nettype none
`timescale 1ns/100ps

module xip_read_seq (
  input  logic        clock,
  input  logic        reset,
  input  logic        xip_start_i,
  input  logic [23:0] xip_addr_i,
  output logic        xip_done_o,
  output logic [31:0] xip_data_o,
  output logic        rq_req_o,
  output logic        rq_lock_o,
  output logic        rq_we_o,
  output logic [4:0]  rq_addr_o,
  output logic [31:0] rq_wdata_o,
  output logic [3:0]  rq_sel_o,
  input  logic        rq_ack_i,
  input  logic [31:0] rq_rdata_i
);
  import spi_xip_pkg::*;

  logic [3:0]  step_q;
  logic [3:0]  next_step;
  logic        issue;
  tx_frame_u   cmd_frame;
  tx_frame_u   frame_q;
  tx_frame_u   src_frame;
  logic        acc_we;
  logic [4:0]  acc_addr;
  logic [31:0] acc_wdata;

  // Access issued for one step as {we, addr, wdata}
  function automatic logic [37:0] step_access(input logic [3:0] step, input tx_frame_u frame);
    case (step)
      seq_tx1:   return {1'b1, reg_tx1, frame.raw.tx1};
      seq_tx0:   return {1'b1, reg_tx0, frame.raw.tx0};
      seq_div:   return {1'b1, reg_divider, 16'h0, xip_divider};
      seq_ss_on: return {1'b1, reg_ss, 32'h1};
      // Go with length 0, a full 64 bit frame
      seq_go:    return {1'b1, reg_ctrl, 32'h1 << ctrl_go_bit};
      seq_poll:  return {1'b0, reg_ctrl, 32'h0};
      seq_rx0:   return {1'b0, reg_rx0, 32'h0};
      default:   return {1'b1, reg_ss, 32'h0};
    endcase
  endfunction

  // Read command: opcode, address, then dummy bits while data returns
  always_comb begin
    cmd_frame.cmd.opcode  = flash_read_op;
    cmd_frame.cmd.address = xip_addr_i;
    cmd_frame.cmd.dummy   = 32'h0;
  end

  // Step sequencing, advanced by each ack
  always_comb begin
    next_step = step_q;
    issue     = 1'b0;
    case (step_q)
      seq_idle: begin
        // Skip the done cycle while start is still up
        if (xip_start_i && !xip_done_o) begin
          next_step = seq_tx1;
          issue     = 1'b1;
        end
      end
      seq_poll: begin
        if (rq_ack_i) begin
          next_step = rq_rdata_i[ctrl_go_bit] ? seq_poll : seq_rx0;
          issue     = 1'b1;
        end
      end
      seq_ss_off: begin
        if (rq_ack_i) begin
          next_step = seq_idle;
        end
      end
      default: begin
        if (rq_ack_i) begin
          next_step = step_q + 4'd1;
          issue     = 1'b1;
        end
      end
    endcase
  end

  assign src_frame = (step_q == seq_idle) ? cmd_frame : frame_q;
  assign {acc_we, acc_addr, acc_wdata} = step_access(next_step, src_frame);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      step_q     <= seq_idle;
      rq_req_o   <= 1'b0;
      rq_lock_o  <= 1'b0;
      xip_done_o <= 1'b0;
    end else begin
      step_q     <= next_step;
      // Bus kept locked for the whole read
      rq_req_o   <= (next_step != seq_idle);
      rq_lock_o  <= (next_step != seq_idle);
      xip_done_o <= (step_q == seq_ss_off) & rq_ack_i;
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      rq_we_o    <= acc_we;
      rq_addr_o  <= acc_addr;
      rq_wdata_o <= acc_wdata;
      rq_sel_o   <= acc_we ? 4'hF : 4'h0;
    end
    if (step_q == seq_idle) begin
      frame_q <= cmd_frame;
    end
    // Flash word sits in RX0 after the frame
    if (step_q == seq_rx0 && rq_ack_i) begin
      xip_data_o <= rq_rdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/spi_reg_arbiter.sv ====
`default_nettype none
`timescale 1ns/100ps

module spi_reg_arbiter (
  input  logic        clock,
  input  logic        reset,
  input  logic        a_req_i,
  input  logic        a_lock_i,
  input  logic        a_we_i,
  input  logic [4:0]  a_addr_i,
  input  logic [31:0] a_wdata_i,
  input  logic [3:0]  a_sel_i,
  output logic        a_ack_o,
  output logic [31:0] a_rdata_o,
  input  logic        b_req_i,
  input  logic        b_lock_i,
  input  logic        b_we_i,
  input  logic [4:0]  b_addr_i,
  input  logic [31:0] b_wdata_i,
  input  logic [3:0]  b_sel_i,
  output logic        b_ack_o,
  output logic [31:0] b_rdata_o,
  output logic        m_req_o,
  output logic        m_we_o,
  output logic [4:0]  m_addr_o,
  output logic [31:0] m_wdata_o,
  output logic [3:0]  m_sel_o,
  input  logic        m_ack_i,
  input  logic [31:0] m_rdata_i
);

  // Owner 0 is the sequencer, 1 the APB port
  logic owner_q;
  logic held_q;
  logic owner;

  // Fixed priority unless the grant is held
  assign owner = held_q ? owner_q : ~a_req_i;

  assign m_req_o   = owner ? b_req_i   : a_req_i;
  assign m_we_o    = owner ? b_we_i    : a_we_i;
  assign m_addr_o  = owner ? b_addr_i  : a_addr_i;
  assign m_wdata_o = owner ? b_wdata_i : a_wdata_i;
  assign m_sel_o   = owner ? b_sel_i   : a_sel_i;

  // Ack only to the holder
  assign a_ack_o   = m_ack_i & ~owner;
  assign b_ack_o   = m_ack_i & owner;
  assign a_rdata_o = m_rdata_i;
  assign b_rdata_o = m_rdata_i;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      owner_q <= 1'b0;
      held_q  <= 1'b0;
    end else begin
      owner_q <= owner;
      // Pending transfer or lock keeps the grant
      held_q  <= (m_req_o & ~m_ack_i) | (owner ? b_lock_i : a_lock_i);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/spi_master_core.sv ====
`default_nettype none
`timescale 1ns/100ps

module spi_master_core (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            m_req_i,
  input  logic                            m_we_i,
  input  logic [4:0]                      m_addr_i,
  input  logic [31:0]                     m_wdata_i,
  input  logic [3:0]                      m_sel_i,
  output logic                            m_ack_o,
  output logic [31:0]                     m_rdata_o,
  output logic                            sck_o,
  output logic [spi_xip_pkg::ss_width-1:0] ss_o,
  output logic                            mosi_o,
  input  logic                            miso_i,
  output logic                            irq_o
);
  import spi_xip_pkg::*;

  tx_frame_u                   tx_q;
  logic [63:0]                 rx_q;
  logic [ctrl_len_width-1:0]   len_q;
  logic                        go_q;
  logic [15:0]                 divider_q;
  logic [15:0]                 div_cnt_q;
  logic [5:0]                  bit_idx_q;
  logic                        access;
  logic                        tick;
  logic                        rise;
  logic [31:0]                 ctrl_word;
  logic [31:0]                 ctrl_new;
  logic [ctrl_len_width-1:0]   len_new;
  logic [5:0]                  first_idx;
  logic [31:0]                 rd_word;

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_v,
                                              input logic [31:0] new_v,
                                              input logic [3:0]  sel);
    logic [31:0] res;
    res = old_v;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        res[8*i +: 8] = new_v[8*i +: 8];
      end
    end
    return res;
  endfunction

  // One access per request, no repeat in the ack cycle
  assign access = m_req_i & ~m_ack_o;

  always_comb begin
    ctrl_word = 32'h0;
    ctrl_word[ctrl_go_bit] = go_q;
    ctrl_word[ctrl_len_lsb +: ctrl_len_width] = len_q;
  end

  assign ctrl_new  = merge_lanes(ctrl_word, m_wdata_i, m_sel_i);
  assign len_new   = ctrl_new[ctrl_len_lsb +: ctrl_len_width];
  // Length 0 runs 64 bits, longer values wrap
  assign first_idx = (len_new == '0) ? 6'd63 : 6'(len_new - 1'b1);

  // SCK edge due this clock
  assign tick = go_q & (div_cnt_q == 16'h0);
  assign rise = tick & ~sck_o;

  always_comb begin
    case (m_addr_i)
      reg_rx0:     rd_word = rx_q[31:0];
      // RX1 reads back at TX1's offset
      reg_tx1:     rd_word = rx_q[63:32];
      reg_ctrl:    rd_word = ctrl_word;
      reg_divider: rd_word = {16'h0, divider_q};
      reg_ss:      rd_word = {{(32-ss_width){1'b0}}, ss_o};
      default:     rd_word = 32'h0;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      m_ack_o   <= 1'b0;
      len_q     <= '0;
      go_q      <= 1'b0;
      divider_q <= 16'h0;
      div_cnt_q <= 16'h0;
      bit_idx_q <= 6'h0;
      ss_o      <= '0;
      sck_o     <= 1'b0;
      mosi_o    <= 1'b0;
      irq_o     <= 1'b0;
    end else begin
      m_ack_o <= access;
      if (access && m_we_i) begin
        // CTRL is frozen while a frame runs
        if (m_addr_i == reg_ctrl && !go_q) begin
          len_q <= len_new;
          if (ctrl_new[ctrl_go_bit]) begin
            go_q      <= 1'b1;
            irq_o     <= 1'b0;
            bit_idx_q <= first_idx;
            div_cnt_q <= divider_q;
            sck_o     <= 1'b0;
            // First bit ready before the first rising edge
            mosi_o    <= tx_q[first_idx];
          end
        end
        if (m_addr_i == reg_divider) begin
          divider_q <= 16'(merge_lanes({16'h0, divider_q}, m_wdata_i, m_sel_i));
        end
        if (m_addr_i == reg_ss) begin
          ss_o <= ss_width'(merge_lanes({{(32-ss_width){1'b0}}, ss_o}, m_wdata_i, m_sel_i));
        end
      end
      if (go_q) begin
        if (tick) begin
          div_cnt_q <= divider_q;
          sck_o     <= ~sck_o;
          // Falling edge moves to the next bit
          if (sck_o) begin
            if (bit_idx_q == 6'h0) begin
              go_q  <= 1'b0;
              irq_o <= 1'b1;
            end else begin
              bit_idx_q <= bit_idx_q - 6'd1;
              mosi_o    <= tx_q[bit_idx_q - 6'd1];
            end
          end
        end else begin
          div_cnt_q <= div_cnt_q - 16'd1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (access) begin
      m_rdata_o <= rd_word;
    end
    if (access && m_we_i && m_addr_i == reg_tx0) begin
      tx_q.raw.tx0 <= merge_lanes(tx_q.raw.tx0, m_wdata_i, m_sel_i);
    end
    if (access && m_we_i && m_addr_i == reg_tx1) begin
      tx_q.raw.tx1 <= merge_lanes(tx_q.raw.tx1, m_wdata_i, m_sel_i);
    end
    // MISO sampled on the rising edge
    if (rise) begin
      rx_q <= {rx_q[62:0], miso_i};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/spi_xip_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module spi_xip_top (
  input  logic                            clock,
  input  logic                            reset,
  input  logic [31:0]                     paddr_i,
  input  logic                            psel_i,
  input  logic                            penable_i,
  input  logic                            pwrite_i,
  input  logic [31:0]                     pwdata_i,
  input  logic [3:0]                      pstrb_i,
  output logic                            pready_o,
  output logic [31:0]                     prdata_o,
  output logic                            pslverr_o,
  output logic                            sck_o,
  output logic [spi_xip_pkg::ss_width-1:0] ss_o,
  output logic                            mosi_o,
  input  logic                            miso_i,
  output logic                            irq_o
);

  // Sequencer side of the register bus
  logic        a_req, a_lock, a_we, a_ack;
  logic [4:0]  a_addr;
  logic [31:0] a_wdata, a_rdata;
  logic [3:0]  a_sel;
  // APB port side
  logic        b_req, b_we, b_ack;
  logic [4:0]  b_addr;
  logic [31:0] b_wdata, b_rdata;
  logic [3:0]  b_sel;
  // Master side
  logic        m_req, m_we, m_ack;
  logic [4:0]  m_addr;
  logic [31:0] m_wdata, m_rdata;
  logic [3:0]  m_sel;
  // XIP handshake
  logic        xip_start, xip_done;
  logic [23:0] xip_addr;
  logic [31:0] xip_data;

  apb_spi_port u_port (
    .clock(clock), .reset(reset),
    .paddr_i(paddr_i), .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .pwdata_i(pwdata_i), .pstrb_i(pstrb_i),
    .pready_o(pready_o), .prdata_o(prdata_o), .pslverr_o(pslverr_o),
    .rq_req_o(b_req), .rq_we_o(b_we), .rq_addr_o(b_addr), .rq_wdata_o(b_wdata),
    .rq_sel_o(b_sel), .rq_ack_i(b_ack), .rq_rdata_i(b_rdata),
    .xip_start_o(xip_start), .xip_addr_o(xip_addr),
    .xip_done_i(xip_done), .xip_data_i(xip_data)
  );

  xip_read_seq u_seq (
    .clock(clock), .reset(reset),
    .xip_start_i(xip_start), .xip_addr_i(xip_addr),
    .xip_done_o(xip_done), .xip_data_o(xip_data),
    .rq_req_o(a_req), .rq_lock_o(a_lock), .rq_we_o(a_we), .rq_addr_o(a_addr),
    .rq_wdata_o(a_wdata), .rq_sel_o(a_sel), .rq_ack_i(a_ack), .rq_rdata_i(a_rdata)
  );

  // The APB port never locks the bus
  spi_reg_arbiter u_arb (
    .clock(clock), .reset(reset),
    .a_req_i(a_req), .a_lock_i(a_lock), .a_we_i(a_we), .a_addr_i(a_addr),
    .a_wdata_i(a_wdata), .a_sel_i(a_sel), .a_ack_o(a_ack), .a_rdata_o(a_rdata),
    .b_req_i(b_req), .b_lock_i(1'b0), .b_we_i(b_we), .b_addr_i(b_addr),
    .b_wdata_i(b_wdata), .b_sel_i(b_sel), .b_ack_o(b_ack), .b_rdata_o(b_rdata),
    .m_req_o(m_req), .m_we_o(m_we), .m_addr_o(m_addr), .m_wdata_o(m_wdata),
    .m_sel_o(m_sel), .m_ack_i(m_ack), .m_rdata_i(m_rdata)
  );

  spi_master_core u_master (
    .clock(clock), .reset(reset),
    .m_req_i(m_req), .m_we_i(m_we), .m_addr_i(m_addr), .m_wdata_i(m_wdata),
    .m_sel_i(m_sel), .m_ack_o(m_ack), .m_rdata_o(m_rdata),
    .sck_o(sck_o), .ss_o(ss_o), .mosi_o(mosi_o), .miso_i(miso_i), .irq_o(irq_o)
  );

endmodule

`default_nettype wire

// ==== bench/spi_flash_model.sv ====
`default_nettype none
`timescale 1ns/100ps

module spi_flash_model (
  input  logic sck_i,
  input  logic ss_i,
  input  logic mosi_i,
  output logic miso_o
);
  import spi_xip_pkg::*;

  logic [31:0] cmd_q      = '0;
  logic [31:0] word_q     = '0;
  logic [5:0]  bit_cnt    = '0;
  logic        sending    = 1'b0;
  logic        miso_q     = 1'b0;
  // Select edges seen and frames started, equal means no fresh edge
  logic [7:0]  select_cnt = '0;
  logic [7:0]  served_cnt = '0;

  assign miso_o = miso_q;

  always @(posedge ss_i) begin
    select_cnt <= select_cnt + 8'd1;
  end

  // Opcode and address in on rising SCK
  always @(posedge sck_i) begin : shift_in
    logic [31:0] cmd_next;
    cmd_next = {cmd_q[30:0], mosi_i};
    // A frame may only start right after a select edge
    if (ss_i && (bit_cnt != 6'd0 || select_cnt != served_cnt)) begin
      if (bit_cnt == 6'd0) begin
        served_cnt <= select_cnt;
      end
      cmd_q   <= cmd_next;
      bit_cnt <= bit_cnt + 6'd1;
      if (bit_cnt == 6'd31) begin
        sending <= (cmd_next[31:24] == flash_read_op);
        word_q  <= {8'hA5, cmd_next[23:0]};
      end else if (bit_cnt == 6'd63) begin
        sending <= 1'b0;
      end
    end
  end

  // Data out on falling SCK, counts 32..63 map to bits 31..0
  always @(negedge sck_i) begin
    if (ss_i && sending) begin
      miso_q <= word_q[~bit_cnt[4:0]];
    end else begin
      miso_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== bench/spi_xip_assert.sv ====
`default_nettype none
`timescale 1ns/100ps

module spi_xip_assert (
  input logic                            clock,
  input logic                            reset,
  input logic                            psel_i,
  input logic                            penable_i,
  input logic                            pready_i,
  input logic                            pslverr_i,
  input logic                            sck_i,
  input logic [spi_xip_pkg::ss_width-1:0] ss_i
);

  int unsigned ready_fails = 0;
  int unsigned sck_fails   = 0;
  int unsigned err_fails   = 0;
  int unsigned failures;

  // Total seen by the testbench
  assign failures = ready_fails + sck_fails + err_fails;

  // Ready only inside an access phase
  ready_in_access: assert property (@(posedge clock) disable iff (reset)
    pready_i |-> (psel_i && penable_i))
  else begin
    $error("pready_o high outside an APB access phase");
    ready_fails++;
  end

  // No clock on the wire without a selected slave
  sck_needs_select: assert property (@(posedge clock) disable iff (reset)
    (ss_i == '0) |-> !sck_i)
  else begin
    $error("sck_o toggling while no slave is selected");
    sck_fails++;
  end

  // Error response completes in the first access cycle
  err_with_ready: assert property (@(posedge clock) disable iff (reset)
    pslverr_i |-> (pready_i && $rose(penable_i)))
  else begin
    $error("pslverr_o high outside the first access cycle or without pready_o");
    err_fails++;
  end

endmodule

bind spi_xip_top spi_xip_assert spi_xip_assert_i (
  .clock(clock), .reset(reset), .psel_i(psel_i), .penable_i(penable_i),
  .pready_i(pready_o), .pslverr_i(pslverr_o), .sck_i(sck_o), .ss_i(ss_o)
);

`default_nettype wire

// ==== bench/spi_xip_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module spi_xip_tb;
  import spi_xip_pkg::*;

  localparam int ready_limit = 2000;
  localparam int poll_limit  = 400;

  // Row kinds
  localparam logic [2:0] k_write   = 3'd0;
  localparam logic [2:0] k_read    = 3'd1;
  localparam logic [2:0] k_flash   = 3'd2;
  localparam logic [2:0] k_bad     = 3'd3;
  localparam logic [2:0] k_poll    = 3'd4;
  localparam logic [2:0] k_pin_ss  = 3'd5;
  localparam logic [2:0] k_pin_irq = 3'd6;

  typedef struct packed {
    logic [2:0]  kind;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] want;
    logic        want_err;
  } row_t;

  logic                clock;
  logic                reset;
  logic [31:0]         paddr;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [31:0]         pwdata;
  logic [3:0]          pstrb;
  logic                pready;
  logic [31:0]         prdata;
  logic                pslverr;
  logic                sck;
  logic [ss_width-1:0] ss;
  logic                mosi;
  logic                miso;
  logic                irq;

  row_t        rows [0:63];
  int          row_count;
  int          fail_count;
  logic [15:0] lfsr_q;

  spi_xip_top spi_xip_top_i (
    .clock(clock), .reset(reset),
    .paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .pwdata_i(pwdata), .pstrb_i(pstrb),
    .pready_o(pready), .prdata_o(prdata), .pslverr_o(pslverr),
    .sck_o(sck), .ss_o(ss), .mosi_o(mosi), .miso_i(miso), .irq_o(irq)
  );

  // Flash on select line 0
  spi_flash_model spi_flash_model_i (
    .sck_i(sck), .ss_i(ss[0]), .mosi_i(mosi), .miso_o(miso)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #10 clock = ~clock;
    end
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      fail_count++;
      stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s is 0x%08h, expected 0x%08h",
                                  $time, name, got, want));
    end
  endtask

  // Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  // One LFSR step per bit
  task automatic random_bits(input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      bits   = {bits[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  function automatic logic [31:0] ctrl_addr(input logic [4:0] offset);
    return ctrl_base + {27'h0, offset};
  endfunction

  task automatic add_row(input logic [2:0] kind, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [31:0] want,
                         input logic want_err);
    rows[row_count] = {kind, addr, wdata, want, want_err};
    row_count++;
  endtask

  // Flash word is 0xA5 over the low 24 address bits
  task automatic add_flash_row(input logic [31:0] addr);
    add_row(k_flash, addr, 32'h0, {8'hA5, addr[23:0]}, 1'b0);
  endtask

  task automatic build_table();
    logic [31:0] bits;
    logic [31:0] go_word;
    logic [23:0] manual_addr;
    go_word     = 32'h1 << ctrl_go_bit;
    manual_addr = 24'h2468AC;
    // Readback through the control window
    add_row(k_write, ctrl_addr(reg_divider), 32'h3, 32'h0, 1'b0);
    add_row(k_read, ctrl_addr(reg_divider), 32'h0, 32'h3, 1'b0);
    add_row(k_write, ctrl_addr(reg_ss), 32'h5A, 32'h0, 1'b0);
    add_row(k_pin_ss, 32'h0, 32'h0, 32'h5A, 1'b0);
    add_row(k_read, ctrl_addr(reg_ss), 32'h0, 32'h5A, 1'b0);
    add_row(k_write, ctrl_addr(reg_ss), 32'h0, 32'h0, 1'b0);
    add_row(k_pin_ss, 32'h0, 32'h0, 32'h0, 1'b0);
    // Back to back XIP reads
    add_flash_row(32'h3000_1234);
    add_flash_row(32'h3ABC_DEF0);
    add_flash_row(flash_last);
    for (int i = 0; i < 4; i++) begin
      random_bits(24, bits);
      add_flash_row(flash_base | bits);
    end
    // Sequencer programs a divider of 1
    add_row(k_read, ctrl_addr(reg_divider), 32'h0, 32'h1, 1'b0);
    // Outside both windows
    add_row(k_bad, 32'h2000_0000, 32'h0, 32'h0, 1'b1);
    add_row(k_bad, ctrl_last + 32'h1, 32'h0, 32'h0, 1'b1);
    add_row(k_bad, flash_last + 32'h1, 32'h0, 32'h0, 1'b1);
    add_row(k_bad, ctrl_base - 32'h1, 32'h0, 32'h0, 1'b1);
    add_flash_row(32'h3055_AA00);
    add_row(k_read, ctrl_addr(reg_ss), 32'h0, 32'h0, 1'b0);
    // Manual read frame by hand
    add_row(k_write, ctrl_addr(reg_tx1), {flash_read_op, manual_addr}, 32'h0, 1'b0);
    add_row(k_write, ctrl_addr(reg_tx0), 32'h0, 32'h0, 1'b0);
    add_row(k_write, ctrl_addr(reg_divider), 32'h3, 32'h0, 1'b0);
    add_row(k_write, ctrl_addr(reg_ss), 32'h1, 32'h0, 1'b0);
    add_row(k_write, ctrl_addr(reg_ctrl), go_word, 32'h0, 1'b0);
    add_row(k_poll, ctrl_addr(reg_ctrl), go_word, 32'h0, 1'b0);
    add_row(k_read, ctrl_addr(reg_rx0), 32'h0, {8'hA5, manual_addr}, 1'b0);
    add_row(k_read, ctrl_addr(reg_ctrl), 32'h0, 32'h0, 1'b0);
    add_row(k_pin_irq, 32'h0, 32'h0, 32'h1, 1'b0);
    // Second go without a new select edge, flash stays quiet
    add_row(k_write, ctrl_addr(reg_ctrl), go_word, 32'h0, 1'b0);
    add_row(k_pin_irq, 32'h0, 32'h0, 32'h0, 1'b0);
    add_row(k_poll, ctrl_addr(reg_ctrl), go_word, 32'h0, 1'b0);
    add_row(k_read, ctrl_addr(reg_rx0), 32'h0, 32'h0, 1'b0);
    add_row(k_write, ctrl_addr(reg_ss), 32'h0, 32'h0, 1'b0);
    random_bits(24, bits);
    add_flash_row(flash_base | bits);
  endtask

  task automatic apb_transfer(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int cycles;
    @(posedge clock);
    paddr   <= addr;
    pwrite  <= write;
    pwdata  <= wdata;
    pstrb   <= write ? 4'hF : 4'h0;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clock);
    penable <= 1'b1;
    cycles = 0;
    // Access phase until pready
    do begin
      @(posedge clock);
      cycles++;
    end while (!pready && cycles < ready_limit);
    if (!pready) begin
      stop_with_failure($sformatf("No pready_o within %0d cycles for address 0x%08h",
                                  cycles, addr));
    end
    rdata   = prdata;
    err     = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apply_row(input int idx);
    row_t        row;
    logic [31:0] rdata;
    logic        err;
    int          polls;
    row = rows[idx];
    case (row.kind)
      k_write: begin
        apb_transfer(1'b1, row.addr, row.wdata, rdata, err);
        check_value($sformatf("pslverr_o row %0d", idx), err, row.want_err);
      end
      k_read, k_flash, k_bad: begin
        apb_transfer(1'b0, row.addr, 32'h0, rdata, err);
        check_value($sformatf("pslverr_o row %0d", idx), err, row.want_err);
        if (row.kind != k_bad) begin
          check_value($sformatf("prdata_o row %0d", idx), rdata, row.want);
        end
        // Select released before the XIP read completes
        if (row.kind == k_flash) begin
          check_value($sformatf("ss_o row %0d", idx), ss, 32'h0);
        end
      end
      k_poll: begin
        polls = 0;
        rdata = row.wdata;
        while ((rdata & row.wdata) != 32'h0 && polls < poll_limit) begin
          apb_transfer(1'b0, row.addr, 32'h0, rdata, err);
          polls++;
        end
        if ((rdata & row.wdata) != 32'h0) begin
          stop_with_failure($sformatf("Go bit still set after %0d polls in row %0d",
                                      polls, idx));
        end
      end
      k_pin_ss: check_value($sformatf("ss_o row %0d", idx), ss, row.want);
      default:  check_value($sformatf("irq_o row %0d", idx), irq, row.want);
    endcase
  endtask

  initial begin
    reset      = 1'b1;
    paddr      = 32'h0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = 32'h0;
    pstrb      = 4'h0;
    lfsr_q     = 16'd17;
    row_count  = 0;
    fail_count = 0;
    build_table();
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < row_count; i++) begin
      apply_row(i);
      check_value("assertion failures", spi_xip_top_i.spi_xip_assert_i.failures, 32'h0);
    end
    if (fail_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      stop_with_failure("Checks failed during the run");
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/spi_xip_pkg.sv
verilog/apb_spi_port.sv
verilog/xip_read_seq.sv
verilog/spi_reg_arbiter.sv
verilog/spi_master_core.sv
verilog/spi_xip_top.sv
bench/spi_flash_model.sv
bench/spi_xip_assert.sv
bench/spi_xip_tb.sv

// ==== Bender.yml ====
package:
  name: spi_xip

sources:
  - verilog/spi_xip_pkg.sv
  - verilog/apb_spi_port.sv
  - verilog/xip_read_seq.sv
  - verilog/spi_reg_arbiter.sv
  - verilog/spi_master_core.sv
  - verilog/spi_xip_top.sv
  - target: simulation
    files:
      - bench/spi_flash_model.sv
      - bench/spi_xip_assert.sv
      - bench/spi_xip_tb.sv
